// ==== realign_pkg.sv ====
`default_nettype none

package realign_pkg;

   // Data path
   localparam int DATA_W = 32;
   localparam int BYTES  = DATA_W / 8;
   localparam int OFF_W  = $clog2(BYTES);  // Byte offset inside a word

   // Transfer geometry
   localparam int LEN_W = 12;  // Up to 4095 bytes
   localparam int CNT_W = LEN_W + 1 - OFF_W;  // Beat and word counters

endpackage

`default_nettype wire

// ==== burst_align.sv ====
`default_nettype none

// Joins consecutive beats so that the output word starts at the byte
// given by offset_i. One extra word is flushed after the final beat.
module burst_align import realign_pkg::*; (
   input  wire              clk_i,
   input  wire              rst_i,
   input  wire [OFF_W-1:0]  offset_i,
   input  wire              start_i,
   input  wire              burst_last_i,
   input  wire              transfer_last_i,
   input  wire [DATA_W-1:0] data_in_i,
   input  wire              valid_in_i,
   output logic [DATA_W-1:0] data_out_o,
   output logic              valid_out_o,
   output logic              last_transfer_o,
   output logic              empty_o
);

   logic [DATA_W-1:0] stored_data;  // Previous beat
   logic              seen;         // First beat of transfer taken
   logic              flush;

   // Upper bytes of the stored beat, then the low bytes of the current one
   always_comb begin
      int src;

      data_out_o = '0;
      for (int b = 0; b < BYTES; b++) begin
         src = b + int'(offset_i);
         if (src < BYTES) begin
            data_out_o[8*b +: 8] = stored_data[8*src +: 8];
         end else begin
            data_out_o[8*b +: 8] = data_in_i[8*(src - BYTES) +: 8];
         end
      end
   end

   assign valid_out_o     = (seen && valid_in_i) || flush;
   assign last_transfer_o = flush;
   assign empty_o         = !valid_out_o;  // Nothing left to push out

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         seen  <= 1'b0;
         flush <= 1'b0;
      end else begin
         flush <= burst_last_i && transfer_last_i;  // Final beat of final burst
         if (valid_in_i) begin
            seen <= 1'b1;
         end else if (start_i) begin
            seen <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (valid_in_i) begin
         stored_data <= data_in_i;
      end
   end

endmodule

`default_nettype wire

// ==== xfer_tracker.sv ====
`default_nettype none

// Transfer geometry and beat counting
module xfer_tracker import realign_pkg::*; (
   input  wire              clk_i,
   input  wire              rst_i,
   input  wire              start_i,
   input  wire [OFF_W-1:0]  addr_off_i,
   input  wire [LEN_W-1:0]  len_i,
   input  wire              valid_i,
   input  wire              burst_last_i,
   output logic             xfer_last_o,
   output logic [CNT_W-1:0] words_total_o,
   output logic [BYTES-1:0] tail_strb_o
);

   logic [LEN_W:0]     span;        // Offset plus length, rounded up
   logic [LEN_W:0]     word_span;   // Length, rounded up
   logic [BYTES-1:0]   tail_next;
   logic [CNT_W-1:0]   beats_total;
   logic [CNT_W-1:0]   burst_base;  // Beats of completed bursts
   logic [CNT_W-1:0]   burst_beats; // Beats in the open burst
   logic [CNT_W-1:0]   beat_cnt;
   logic               active;

   always_comb begin
      span      = {1'b0, len_i} + (LEN_W + 1)'(addr_off_i) + (LEN_W + 1)'(BYTES - 1);
      word_span = {1'b0, len_i} + (LEN_W + 1)'(BYTES - 1);

      // Low remainder bytes or all bytes for a whole last word
      for (int b = 0; b < BYTES; b++) begin
         tail_next[b] = (len_i[OFF_W-1:0] == '0) || (b < int'(len_i[OFF_W-1:0]));
      end
   end

   assign beat_cnt    = burst_base + burst_beats;
   assign xfer_last_o = active && valid_i && (beat_cnt == beats_total - 1'b1);

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         beats_total   <= '0;
         words_total_o <= '0;
         tail_strb_o   <= '0;
         burst_base    <= '0;
         burst_beats   <= '0;
         active        <= 1'b0;
      end else if (start_i) begin
         beats_total   <= span[LEN_W:OFF_W];
         words_total_o <= word_span[LEN_W:OFF_W];
         tail_strb_o   <= tail_next;
         burst_base    <= '0;
         burst_beats   <= '0;
         active        <= 1'b1;
      end else if (valid_i && active) begin
         if (burst_last_i) begin
            // A burst may close before the transfer total
            burst_base  <= beat_cnt + 1'b1;
            burst_beats <= '0;
         end else begin
            burst_beats <= burst_beats + 1'b1;
         end
         if (xfer_last_o) begin
            active <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// ==== word_packer.sv ====
`default_nettype none

// Keeps only the transfer's words and marks the last one
module word_packer import realign_pkg::*; (
   input  wire              clk_i,
   input  wire              rst_i,
   input  wire              start_i,
   input  wire [DATA_W-1:0] aligned_data_i,
   input  wire              aligned_valid_i,
   input  wire [CNT_W-1:0]  words_total_i,
   input  wire [BYTES-1:0]  tail_strb_i,
   output logic [DATA_W-1:0] data_o,
   output logic              valid_o,
   output logic [BYTES-1:0]  strb_o,
   output logic              last_o,
   output logic              busy_o
);

   logic [CNT_W-1:0] word_cnt;  // Words emitted since start
   logic             take;
   logic             final_word;

   assign take       = aligned_valid_i && (word_cnt < words_total_i);  // Surplus dropped
   assign final_word = word_cnt == words_total_i - 1'b1;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         word_cnt <= '0;
         valid_o  <= 1'b0;
         strb_o   <= '0;
         last_o   <= 1'b0;
      end else begin
         if (start_i) begin
            word_cnt <= '0;
         end else if (take) begin
            word_cnt <= word_cnt + 1'b1;
         end

         valid_o <= take;
         last_o  <= take && final_word;

         if (!take) begin
            strb_o <= '0;
         end else if (final_word) begin
            strb_o <= tail_strb_i;
         end else begin
            strb_o <= '1;
         end
      end
   end

   // Busy until the cycle after last
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         busy_o <= 1'b0;
      end else if (start_i) begin
         busy_o <= 1'b1;
      end else if (last_o) begin
         busy_o <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (take) begin
         data_o <= aligned_data_i;
      end
   end

endmodule

`default_nettype wire

// ==== realign_top.sv ====
`default_nettype none

module realign_top import realign_pkg::*; (
   input  wire              clk_i,
   input  wire              rst_i,
   input  wire              start_i,
   input  wire [OFF_W-1:0]  addr_off_i,
   input  wire [LEN_W-1:0]  len_i,
   input  wire [DATA_W-1:0] data_i,
   input  wire              valid_i,
   input  wire              burst_last_i,
   output logic [DATA_W-1:0] data_o,
   output logic              valid_o,
   output logic [BYTES-1:0]  strb_o,
   output logic              last_o,
   output logic              busy_o
);

   logic              xfer_last;
   logic [DATA_W-1:0] aligned_data;
   logic              aligned_valid;
   logic [CNT_W-1:0]  words_total;
   logic [BYTES-1:0]  tail_strb;

   xfer_tracker xfer_tracker_i (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .start_i       (start_i),
      .addr_off_i    (addr_off_i),
      .len_i         (len_i),
      .valid_i       (valid_i),
      .burst_last_i  (burst_last_i),
      .xfer_last_o   (xfer_last),
      .words_total_o (words_total),
      .tail_strb_o   (tail_strb)
   );

   // Offset comes straight from the port, held for the transfer
   burst_align burst_align_i (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .offset_i        (addr_off_i),
      .start_i         (start_i),
      .burst_last_i    (burst_last_i),
      .transfer_last_i (xfer_last),
      .data_in_i       (data_i),
      .valid_in_i      (valid_i),
      .data_out_o      (aligned_data),
      .valid_out_o     (aligned_valid),
      .last_transfer_o (),
      .empty_o         ()
   );

   word_packer word_packer_i (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .start_i         (start_i),
      .aligned_data_i  (aligned_data),
      .aligned_valid_i (aligned_valid),
      .words_total_i   (words_total),
      .tail_strb_i     (tail_strb),
      .data_o          (data_o),
      .valid_o         (valid_o),
      .strb_o          (strb_o),
      .last_o          (last_o),
      .busy_o          (busy_o)
   );

endmodule

`default_nettype wire

// ==== tb_realign.sv ====
`default_nettype none

module tb_realign import realign_pkg::*; ();

   localparam int MEM_WORDS     = 128;
   localparam int WAIT_LAST_MAX = 400;  // Cycles until last_o
   localparam int WAIT_IDLE_MAX = 50;

   logic              clk_i;
   logic              rst_i;
   logic              start_i;
   logic [OFF_W-1:0]  addr_off_i;
   logic [LEN_W-1:0]  len_i;
   logic [DATA_W-1:0] data_i;
   logic              valid_i;
   logic              burst_last_i;
   logic [DATA_W-1:0] data_o;
   logic              valid_o;
   logic [BYTES-1:0]  strb_o;
   logic              last_o;
   logic              busy_o;

   logic [DATA_W-1:0] mem [MEM_WORDS];

   // One table row per case
   string      case_name  [$];
   int         case_off   [$];
   int         case_len   [$];
   int         case_burst [$];  // Beats per burst
   logic [7:0] case_gap   [$];  // Bit k%8 set gives an idle cycle after beat k

   // Output words of the running case
   logic [DATA_W-1:0] got_data [$];
   logic [BYTES-1:0]  got_strb [$];
   logic              got_last [$];

   int value_errs;
   int timeout_errs;

   realign_top realign_top_i (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .start_i      (start_i),
      .addr_off_i   (addr_off_i),
      .len_i        (len_i),
      .data_i       (data_i),
      .valid_i      (valid_i),
      .burst_last_i (burst_last_i),
      .data_o       (data_o),
      .valid_o      (valid_o),
      .strb_o       (strb_o),
      .last_o       (last_o),
      .busy_o       (busy_o)
   );

   always #10 clk_i = ~clk_i;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic fill_memory();
      logic [31:0] state;
      state = 32'd78754;
      for (int a = 0; a < MEM_WORDS; a++) begin
         state  = xorshift(state);
         mem[a] = state;
      end
   endtask

   task automatic add_case(input string name, input int off, input int len,
                           input int burst, input logic [7:0] gap);
      case_name.push_back(name);
      case_off.push_back(off);
      case_len.push_back(len);
      case_burst.push_back(burst);
      case_gap.push_back(gap);
   endtask

   task automatic load_cases();
      //       name          off  len  burst gap
      add_case("aligned_4",    0,   4,  16,  8'h00);
      add_case("aligned_16",   0,  16,  16,  8'h00);
      add_case("aligned_64",   0,  64,  16,  8'h00);
      add_case("off0_len5",    0,   5,  16,  8'h00);
      add_case("off1_len1",    1,   1,  16,  8'h00);
      add_case("off1_len3",    1,   3,  16,  8'h00);
      add_case("off1_len7",    1,   7,  16,  8'h00);
      add_case("off1_len21",   1,  21,  16,  8'h00);
      add_case("off2_len2",    2,   2,  16,  8'h00);
      add_case("off2_len3",    2,   3,  16,  8'h00);
      add_case("off2_len14",   2,  14,  16,  8'h00);
      add_case("off3_len1",    3,   1,  16,  8'h00);
      add_case("off3_len2",    3,   2,  16,  8'h00);
      add_case("off3_len9",    3,   9,  16,  8'h00);
      add_case("off3_len33",   3,  33,  16,  8'h00);
      add_case("split_off0",   0,  28,   3,  8'h11);
      add_case("split_off1",   1,  45,   4,  8'ha6);
      add_case("split_off3",   3,  30,   2,  8'hff);
   endtask

   // Little endian memory byte at a byte address
   function automatic logic [7:0] mem_byte(input int addr);
      logic [DATA_W-1:0] w;
      w = mem[addr / BYTES];
      return w[8 * (addr % BYTES) +: 8];
   endfunction

   function automatic logic [DATA_W-1:0] expected_word(input int first, input int len,
                                                       input int w);
      logic [DATA_W-1:0] word;
      word = '0;
      for (int b = 0; b < BYTES; b++) begin
         if (w * BYTES + b < len) begin
            word[8 * b +: 8] = mem_byte(first + w * BYTES + b);
         end
      end
      return word;
   endfunction

   // Final word strobe covers the bytes that lie inside the length
   function automatic logic [BYTES-1:0] expected_tail(input int len);
      logic [BYTES-1:0] strb;
      int               last_w;
      last_w = (len - 1) / BYTES;  // Index of the final word
      for (int b = 0; b < BYTES; b++) begin
         strb[b] = (last_w * BYTES + b) < len;
      end
      return strb;
   endfunction

   function automatic logic [DATA_W-1:0] byte_mask(input logic [BYTES-1:0] strb);
      logic [DATA_W-1:0] mask;
      for (int b = 0; b < BYTES; b++) begin
         mask[8 * b +: 8] = {8{strb[b]}};
      end
      return mask;
   endfunction

   task automatic check_word(input string label, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
      if (act !== exp) begin
         value_errs++;
         $display("Fail %s: expected %h, actual %h", label, exp, act);
      end
   endtask

   task automatic check_strb(input string label, input logic [BYTES-1:0] exp,
                             input logic [BYTES-1:0] act);
      if (act !== exp) begin
         value_errs++;
         $display("Fail %s: expected %b, actual %b", label, exp, act);
      end
   endtask

   task automatic check_flag(input string label, input logic exp, input logic act);
      if (act !== exp) begin
         value_errs++;
         $display("Fail %s: expected %b, actual %b", label, exp, act);
      end
   endtask

   task automatic check_count(input string label, input logic [CNT_W-1:0] exp,
                              input logic [CNT_W-1:0] act);
      if (act !== exp) begin
         value_errs++;
         $display("Fail %s: expected %0d, actual %0d", label, exp, act);
      end
   endtask

   task automatic check_reset_state(input string label);
      check_flag({label, " valid_o"}, 1'b0, valid_o);
      check_flag({label, " last_o"}, 1'b0, last_o);
      check_flag({label, " busy_o"}, 1'b0, busy_o);
      check_strb({label, " strb_o"}, '0, strb_o);
   endtask

   task automatic drive_idle();
      data_i       = '0;
      valid_i      = 1'b0;
      burst_last_i = 1'b0;
   endtask

   task automatic start_transfer(input int off, input int len);
      @(negedge clk_i);
      start_i    = 1'b1;
      addr_off_i = OFF_W'(off);  // Held until the next transfer
      len_i      = LEN_W'(len);
      @(negedge clk_i);
      start_i = 1'b0;
   endtask

   task automatic drive_beats(input int base, input int nbeats, input int burst,
                              input logic [7:0] gap);
      for (int k = 0; k < nbeats; k++) begin
         @(negedge clk_i);
         data_i       = mem[base + k];
         valid_i      = 1'b1;
         burst_last_i = ((k + 1) % burst == 0) || (k == nbeats - 1);
         if (gap[k % 8]) begin
            @(negedge clk_i);
            drive_idle();
         end
      end
      @(negedge clk_i);
      drive_idle();
   endtask

   task automatic collect_words(input string name);
      int   cycles;
      logic done;
      cycles = 0;
      done   = 1'b0;
      while (!done && cycles < WAIT_LAST_MAX) begin
         @(negedge clk_i);
         cycles++;
         if (valid_o) begin
            got_data.push_back(data_o);
            got_strb.push_back(strb_o);
            got_last.push_back(last_o);
            check_flag({name, " busy_o with output"}, 1'b1, busy_o);
            done = last_o;
         end
      end
      if (!done) begin
         timeout_errs++;
         $display("Timeout: case %s gave no last_o within %0d cycles", name, WAIT_LAST_MAX);
      end
   endtask

   // No word may follow last_o
   task automatic wait_idle(input string name);
      int cycles;
      cycles = 0;
      while (busy_o && cycles < WAIT_IDLE_MAX) begin
         @(negedge clk_i);
         cycles++;
         check_flag({name, " valid_o after last_o"}, 1'b0, valid_o);
      end
      if (busy_o) begin
         timeout_errs++;
         $display("Timeout: case %s kept busy_o high after the transfer", name);
      end
      repeat (2) begin
         @(negedge clk_i);
         check_flag({name, " valid_o when idle"}, 1'b0, valid_o);
      end
   endtask

   task automatic run_case(input int ci);
      string             name;
      int                base;
      int                first;
      int                nbeats;
      int                nwords;
      logic [BYTES-1:0]  exp_strb;
      logic [DATA_W-1:0] exp_data;
      logic [DATA_W-1:0] mask;

      name   = case_name[ci];
      base   = (ci * 7) % 96;  // Word address of the first beat
      first  = base * BYTES + case_off[ci];
      nbeats = (case_off[ci] + case_len[ci] + BYTES - 1) / BYTES;
      nwords = (case_len[ci] + BYTES - 1) / BYTES;
      got_data.delete();
      got_strb.delete();
      got_last.delete();

      start_transfer(case_off[ci], case_len[ci]);
      fork
         drive_beats(base, nbeats, case_burst[ci], case_gap[ci]);
         begin
            collect_words(name);
            wait_idle(name);
         end
      join

      check_count({name, " word count"}, CNT_W'(nwords), CNT_W'(got_data.size()));
      for (int w = 0; w < got_data.size() && w < nwords; w++) begin
         exp_strb = (w == nwords - 1) ? expected_tail(case_len[ci]) : '1;
         mask     = byte_mask(exp_strb);  // Bytes past the length are free
         exp_data = expected_word(first, case_len[ci], w) & mask;
         check_strb($sformatf("%s word %0d strb", name, w), exp_strb, got_strb[w]);
         check_word($sformatf("%s word %0d data", name, w), exp_data, got_data[w] & mask);
         check_flag($sformatf("%s word %0d last", name, w), w == nwords - 1, got_last[w]);
      end
   endtask

   initial begin
      clk_i        = 1'b0;
      rst_i        = 1'b1;
      start_i      = 1'b0;
      addr_off_i   = '0;
      len_i        = '0;
      data_i       = '0;
      valid_i      = 1'b0;
      burst_last_i = 1'b0;
      value_errs   = 0;
      timeout_errs = 0;

      fill_memory();
      load_cases();

      repeat (4) @(negedge clk_i);
      check_reset_state("in reset");
      rst_i = 1'b0;
      @(negedge clk_i);
      check_reset_state("after reset");

      // Each case starts right after the previous one went idle
      for (int ci = 0; ci < case_name.size(); ci++) begin
         run_case(ci);
      end

      $display("Errors: %0d wrong values, %0d timeouts", value_errs, timeout_errs);
      if (value_errs == 0 && timeout_errs == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
realign_pkg.sv
burst_align.sv
xfer_tracker.sv
word_packer.sv
realign_top.sv
tb_realign.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the realigner testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_realign -f vlog.f \
   -o sim_realign > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_realign > sim.log 2>&1 || { cat sim.log; echo "Simulator error"; exit 1; }
cat sim.log

grep -q "=== FAIL ===" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "Simulation did not finish"; exit 1; }
echo "Simulation passed"
